/* source/smArithPkg.sv */
// Sign-magnitude arithmetic definitions
package smArithPkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 5;

    // byte offsets of the APB register map.
    localparam logic [ADDR_WIDTH-1:0] REG_OP1    = 5'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_OP2    = 5'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 5'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 5'h0C;
    localparam logic [ADDR_WIDTH-1:0] REG_RESULT = 5'h10;

    typedef struct packed {
        logic                  sign;
        logic [DATA_WIDTH-2:0] mag;
    } smFields_t;

    // the bus moves raw words, the core looks at sign and magnitude.
    typedef union packed {
        smFields_t             fields;
        logic [DATA_WIDTH-1:0] raw;
    } smWord_u;

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } aluOp_e;

    typedef struct packed {
        aluOp_e  op;
        logic    cin;
        smWord_u op1;
        smWord_u op2;
    } smCmd_t;

    typedef struct packed {
        smWord_u value;
        logic    overflow;
        logic    zero;
    } smResult_t;

endpackage

/* source/lookaheadAdder.sv */
// Carry-lookahead adder
`timescale 1ns/1ps

module lookaheadAdder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int GROUPS    = (WIDTH + 3) / 4;
    localparam int PAD_WIDTH = GROUPS * 4;

    logic [PAD_WIDTH-1:0] gBit;
    logic [PAD_WIDTH-1:0] pBit;
    logic [PAD_WIDTH:0]   carry;
    logic [GROUPS-1:0]    grpG;
    logic [GROUPS-1:0]    grpP;
    logic [GROUPS:0]      grpC;

    // bits above WIDTH are zero, so the top group may be partial.
    assign gBit    = PAD_WIDTH'(a & b);
    assign pBit    = PAD_WIDTH'(a ^ b);
    assign grpC[0] = cin;

    for (genvar gi = 0; gi < GROUPS; gi++) begin : gGroup
        logic [3:0] g;
        logic [3:0] p;
        logic       c0;

        assign g  = gBit[4*gi +: 4];
        assign p  = pBit[4*gi +: 4];
        assign c0 = grpC[gi];

        assign grpG[gi] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                        | (p[3] & p[2] & p[1] & g[0]);
        assign grpP[gi] = &p;

        assign carry[4*gi]     = c0;
        assign carry[4*gi + 1] = g[0] | (p[0] & c0);
        assign carry[4*gi + 2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0);
        assign carry[4*gi + 3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                               | (p[2] & p[1] & p[0] & c0);

        // group carry out, looked ahead from the group terms.
        assign grpC[gi + 1] = grpG[gi] | (grpP[gi] & c0);
    end

    assign carry[PAD_WIDTH] = grpC[GROUPS];

    assign sum  = pBit[WIDTH-1:0] ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

/* source/cmdFifo.sv */
// Command FIFO
`timescale 1ns/1ps

module cmdFifo #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  smArithPkg::smCmd_t  pushCmd,
    output logic                full,
    input  logic                pop,
    output smArithPkg::smCmd_t  popCmd,
    output logic                empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    smArithPkg::smCmd_t mem [DEPTH];

    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;
    logic             doPop;

    // pointers wrap by compare, so DEPTH need not be a power of two.
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign doPush = push & ~full;
    assign doPop  = pop & ~empty;

    assign full   = (count == CNT_W'(DEPTH));
    assign empty  = (count == '0);
    assign popCmd = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushCmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/smAluCore.sv */
// Sign-magnitude ALU core
`timescale 1ns/1ps

module smAluCore (
    input  logic                  clk,
    input  logic                  rst,
    input  smArithPkg::smCmd_t    popCmd,
    input  logic                  empty,
    output logic                  pop,
    input  logic                  resultAck,
    output smArithPkg::smResult_t result,
    output logic                  resultValid
);

    // one extra bit so a sum that does not fit in 31 magnitude bits is seen.
    localparam int W = smArithPkg::DATA_WIDTH + 1;

    logic [W-1:0] op1Tc;
    logic [W-1:0] op2Tc;
    logic [W-1:0] addB;
    logic [W-1:0] sumTc;
    logic [W-1:0] sumMag;
    logic         isSub;
    logic         adderCin;
    logic         sumNeg;
    logic         magZero;

    smArithPkg::smResult_t nextResult;

    // a zero magnitude maps to zero whatever the sign, so negative zero is zero.
    function automatic logic [W-1:0] toTwos(input smArithPkg::smWord_u word,
                                            input logic flip);
        logic [W-1:0] magExt;
        magExt = W'(word.fields.mag);
        if (word.fields.mag == '0) begin
            return '0;
        end
        if (word.fields.sign ^ flip) begin
            return ~magExt + 1'b1;
        end
        return magExt;
    endfunction

    assign isSub = (popCmd.op == smArithPkg::OP_SUB);
    assign op1Tc = toTwos(popCmd.op1, 1'b0);
    assign op2Tc = toTwos(popCmd.op2, isSub);

    // for subtract the borrow comes off the negated op2 before the add.
    assign addB     = isSub ? op2Tc - W'(popCmd.cin) : op2Tc;
    assign adderCin = popCmd.cin & ~isSub;

    lookaheadAdder #(
        .WIDTH(W)
    ) i_adder (
        .a   (op1Tc),
        .b   (addB),
        .cin (adderCin),
        .sum (sumTc),
        .cout()
    );

    assign sumNeg  = sumTc[W-1];
    assign sumMag  = sumNeg ? ~sumTc + 1'b1 : sumTc;
    assign magZero = (sumMag[W-3:0] == '0);

    // the stored magnitude keeps its low 31 bits; a zero word is always positive.
    always_comb begin
        nextResult.value.fields.mag  = sumMag[W-3:0];
        nextResult.value.fields.sign = sumNeg & ~magZero;
        nextResult.overflow          = |sumMag[W-1:W-2];
        nextResult.zero              = magZero;
    end

    // pop only when the result slot is free or is being read this cycle.
    assign pop = ~empty & (~resultValid | resultAck);

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (pop) begin
            resultValid <= 1'b1;
        end else if (resultAck) begin
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= nextResult;
        end
    end

endmodule

/* source/apbOperandPort.sv */
// APB operand and result port
`timescale 1ns/1ps

module apbOperandPort (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [smArithPkg::ADDR_WIDTH-1:0]   paddr,
    input  logic [smArithPkg::DATA_WIDTH-1:0]   pwdata,
    output logic [smArithPkg::DATA_WIDTH-1:0]   prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                push,
    output smArithPkg::smCmd_t                  pushCmd,
    input  logic                                full,
    input  smArithPkg::smResult_t               result,
    input  logic                                resultValid,
    output logic                                resultAck
);

    localparam int DW = smArithPkg::DATA_WIDTH;

    logic                access;
    logic                wrAccess;
    logic                rdAccess;
    logic                ctrlWrite;
    logic [DW-1:0]       statusWord;
    smArithPkg::smWord_u op1Reg;
    smArithPkg::smWord_u op2Reg;

    // no wait states, every transfer completes in its access phase.
    assign pready   = 1'b1;
    assign access   = psel & penable;
    assign wrAccess = access & pwrite;
    assign rdAccess = access & ~pwrite;

    assign ctrlWrite = wrAccess && (paddr == smArithPkg::REG_CTRL);
    assign push      = ctrlWrite & ~full;
    assign resultAck = rdAccess && (paddr == smArithPkg::REG_RESULT) && resultValid;

    always_comb begin
        pushCmd.op  = pwdata[0] ? smArithPkg::OP_SUB : smArithPkg::OP_ADD;
        pushCmd.cin = pwdata[1];
        pushCmd.op1 = op1Reg;
        pushCmd.op2 = op2Reg;
    end

    // the result flags mean nothing until a result is held.
    assign statusWord = DW'({result.zero & resultValid,
                             result.overflow & resultValid,
                             full,
                             resultValid});

    always_ff @(posedge clk) begin
        if (rst) begin
            op1Reg.raw <= '0;
            op2Reg.raw <= '0;
        end else if (wrAccess) begin
            if (paddr == smArithPkg::REG_OP1) begin
                op1Reg.raw <= pwdata;
            end
            if (paddr == smArithPkg::REG_OP2) begin
                op2Reg.raw <= pwdata;
            end
        end
    end

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            case (paddr)
                smArithPkg::REG_OP1: begin
                    if (!pwrite) begin
                        prdata = op1Reg.raw;
                    end
                end
                smArithPkg::REG_OP2: begin
                    if (!pwrite) begin
                        prdata = op2Reg.raw;
                    end
                end
                // a full FIFO drops the command.
                smArithPkg::REG_CTRL: pslverr = pwrite ? full : 1'b1;
                smArithPkg::REG_STATUS: begin
                    if (pwrite) begin
                        pslverr = 1'b1;
                    end else begin
                        prdata = statusWord;
                    end
                end
                smArithPkg::REG_RESULT: begin
                    if (pwrite || !resultValid) begin
                        pslverr = 1'b1;
                    end else begin
                        prdata = result.value.raw;
                    end
                end
                default: pslverr = 1'b1;
            endcase
        end
    end

endmodule

/* source/smArithTop.sv */
// Sign-magnitude arithmetic unit
`timescale 1ns/1ps

module smArithTop #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [smArithPkg::ADDR_WIDTH-1:0]   paddr,
    input  logic [smArithPkg::DATA_WIDTH-1:0]   pwdata,
    output logic [smArithPkg::DATA_WIDTH-1:0]   prdata,
    output logic                                pready,
    output logic                                pslverr
);

    logic                  push;
    logic                  full;
    logic                  pop;
    logic                  empty;
    logic                  resultValid;
    logic                  resultAck;
    smArithPkg::smCmd_t    pushCmd;
    smArithPkg::smCmd_t    popCmd;
    smArithPkg::smResult_t result;

    apbOperandPort i_apbOperandPort (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .push       (push),
        .pushCmd    (pushCmd),
        .full       (full),
        .result     (result),
        .resultValid(resultValid),
        .resultAck  (resultAck)
    );

    cmdFifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_cmdFifo (
        .clk    (clk),
        .rst    (rst),
        .push   (push),
        .pushCmd(pushCmd),
        .full   (full),
        .pop    (pop),
        .popCmd (popCmd),
        .empty  (empty)
    );

    smAluCore i_smAluCore (
        .clk        (clk),
        .rst        (rst),
        .popCmd     (popCmd),
        .empty      (empty),
        .pop        (pop),
        .resultAck  (resultAck),
        .result     (result),
        .resultValid(resultValid)
    );

endmodule

/* bench/smArith_sva.sv */
// APB and FIFO handshake assertions
`timescale 1ns/1ps

module smArithSva (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic resultValid,
    input logic resultAck
);

    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("command pushed while the FIFO is full");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("command popped while the FIFO is empty");

    assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");

    // a held result stays until software reads it.
    assert property (@(posedge clk) disable iff (rst) resultValid && !resultAck |=> resultValid)
        else $error("resultValid fell without resultAck");

endmodule

bind smArithTop smArithSva i_smArithSva (.*);

/* bench/smArithTb.sv */
// Sign-magnitude arithmetic unit testbench
`timescale 1ns/1ps

module smArithTb;

    localparam int FIFO_DEPTH = 4;
    localparam int POLL_LIMIT = 20;
    localparam int AW         = smArithPkg::ADDR_WIDTH;

    logic          clk;
    logic          rst;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [AW-1:0] paddr;
    logic [31:0]   pwdata;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;
    logic [31:0]   rdData;
    logic          slvErr;
    int            errorCount;
    int            testErrors;
    int            testCount;

    // expected results of the commands that are still in flight, oldest first.
    smArithPkg::smResult_t expQ[$];

    smArithTop #(.FIFO_DEPTH(FIFO_DEPTH)) i_smArithTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    // setup phase, then access phase; the slave answers without wait states.
    task automatic apbAccess(input logic wr, input logic [AW-1:0] addr,
                             input logic [31:0] wdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdData = prdata;
        slvErr = pslverr;
        checkEq("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [AW-1:0] addr, input logic [31:0] data);
        apbAccess(1'b1, addr, data);
    endtask

    task automatic apbRead(input logic [AW-1:0] addr);
        apbAccess(1'b0, addr, 32'h0);
    endtask

    // expected result from signed integer arithmetic on sign and magnitude.
    function automatic smArithPkg::smResult_t refSmArith(input logic sub, input logic cin,
            input smArithPkg::smWord_u a, input smArithPkg::smWord_u b);
        longint va;
        longint vb;
        longint v;
        longint m;
        smArithPkg::smResult_t r;
        va = a.fields.sign ? -longint'(a.fields.mag) : longint'(a.fields.mag);
        vb = b.fields.sign ? -longint'(b.fields.mag) : longint'(b.fields.mag);
        v  = sub ? va - vb - longint'(cin) : va + vb + longint'(cin);
        m  = (v < 0) ? -v : v;
        r.overflow          = (m > 64'sh7fff_ffff);
        r.value.fields.mag  = m[30:0];
        r.zero              = (m[30:0] == '0);
        r.value.fields.sign = (v < 0) && !r.zero;
        return r;
    endfunction

    task automatic issueCmd(input logic sub, input logic cin, input logic [31:0] a,
                            input logic [31:0] b, input logic expectErr);
        apbWrite(smArithPkg::REG_OP1, a);
        apbWrite(smArithPkg::REG_OP2, b);
        apbWrite(smArithPkg::REG_CTRL, {30'h0, cin, sub});
        checkEq("pslverr", 32'(slvErr), 32'(expectErr));
        if (!expectErr) begin
            expQ.push_back(refSmArith(sub, cin, a, b));
        end
    endtask

    // reads back every outstanding result in order, polling STATUS before each one.
    task automatic drainResults();
        logic [31:0]           status;
        smArithPkg::smResult_t want;
        while (expQ.size() > 0) begin
            want   = expQ.pop_front();
            status = '0;
            for (int p = 0; p < POLL_LIMIT && !status[0]; p++) begin
                apbRead(smArithPkg::REG_STATUS);
                status = rdData;
            end
            if (!status[0]) begin
                $display("no result became valid within %0d STATUS reads", POLL_LIMIT);
                errorCount++;
                expQ.delete();
            end else begin
                apbRead(smArithPkg::REG_RESULT);
                checkEq("result", rdData, want.value.raw);
                checkEq("pslverr", 32'(slvErr), 32'h0);
                checkEq("overflow", 32'(status[2]), 32'(want.overflow));
                checkEq("zero", 32'(status[3]), 32'(want.zero));
            end
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    initial begin
        errorCount = 0;
        testErrors = 0;
        testCount  = 0;
        void'($urandom(32'h43aa));
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apbRead(smArithPkg::REG_STATUS);
        checkEq("status", rdData, 32'h0);
        apbWrite(smArithPkg::REG_OP1, 32'h8000_1234);
        apbWrite(smArithPkg::REG_OP2, 32'h7654_3210);
        apbRead(smArithPkg::REG_OP1);
        checkEq("op1", rdData, 32'h8000_1234);
        apbRead(smArithPkg::REG_OP2);
        checkEq("op2", rdData, 32'h7654_3210);
        apbRead(5'h14);
        checkEq("pslverr", 32'(slvErr), 32'h1);
        checkEq("prdata", rdData, 32'h0);
        endTest("register readback and reset state");

        // mixed signs, carry in, negative zero and zero results.
        issueCmd(1'b0, 1'b0, 32'h0000_0005, 32'h0000_0003, 1'b0);
        issueCmd(1'b0, 1'b1, 32'h0000_0005, 32'h8000_0009, 1'b0);
        issueCmd(1'b1, 1'b0, 32'h8000_0007, 32'h8000_0007, 1'b0);
        issueCmd(1'b1, 1'b1, 32'h0000_000a, 32'h8000_0003, 1'b0);
        drainResults();
        issueCmd(1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000, 1'b0);
        issueCmd(1'b0, 1'b1, 32'h8000_0001, 32'h8000_0000, 1'b0);
        issueCmd(1'b1, 1'b1, 32'h0000_0001, 32'h0000_0000, 1'b0);
        issueCmd(1'b1, 1'b0, 32'h8000_0000, 32'h0000_0004, 1'b0);
        drainResults();
        endTest("directed add and subtract");

        issueCmd(1'b0, 1'b0, 32'h7fff_ffff, 32'h7fff_ffff, 1'b0);
        issueCmd(1'b1, 1'b1, 32'hffff_ffff, 32'h7fff_ffff, 1'b0);
        issueCmd(1'b0, 1'b0, 32'h4000_0000, 32'h4000_0000, 1'b0);
        issueCmd(1'b1, 1'b0, 32'hc000_0001, 32'h4000_0000, 1'b0);
        drainResults();
        endTest("overflow");

        // random commands in short bursts, never more than the unit can hold.
        for (int n = 0; n < 200; n++) begin
            issueCmd(1'($urandom()), 1'($urandom()), $urandom(), $urandom(), 1'b0);
            if (expQ.size() > FIFO_DEPTH || $urandom_range(3) == 0) begin
                drainResults();
            end
        end
        drainResults();
        endTest("random sequence");

        // depth queued plus one held in the core, then the next command bounces.
        for (int n = 0; n <= FIFO_DEPTH; n++) begin
            issueCmd(n[0], 1'b0, 32'h0000_1000 + n, 32'h8000_0100, 1'b0);
        end
        apbRead(smArithPkg::REG_STATUS);
        checkEq("fifoFull", 32'(rdData[1]), 32'h1);
        issueCmd(1'b0, 1'b1, 32'h0000_0001, 32'h0000_0002, 1'b1);
        drainResults();
        endTest("back-pressure");

        apbRead(smArithPkg::REG_RESULT);
        checkEq("pslverr", 32'(slvErr), 32'h1);
        checkEq("prdata", rdData, 32'h0);
        endTest("result read with no valid result");

        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/smArithPkg.sv
source/lookaheadAdder.sv
source/cmdFifo.sv
source/smAluCore.sv
source/apbOperandPort.sv
source/smArithTop.sv
bench/smArith_sva.sv
bench/smArithTb.sv

/* Bender.yml */
package:
  name: sm_arith

sources:
  - source/smArithPkg.sv
  - source/lookaheadAdder.sv
  - source/cmdFifo.sv
  - source/smAluCore.sv
  - source/apbOperandPort.sv
  - source/smArithTop.sv
  - target: test
    files:
      - bench/smArith_sva.sv
      - bench/smArithTb.sv
